//--- common/wr_demux_consts.svh
// --------------------------------------------------
// sizing macros for the write demux: port count,
// ID tracking, counter, data and response widths
// --------------------------------------------------
`ifndef WR_DEMUX_CONSTS_SVH
`define WR_DEMUX_CONSTS_SVH

// master ports and the width of a port select
`define WD_NUM_PORTS 4
`define WD_SEL_WIDTH 2

// full AXI ID and the low bits that get a counter
`define WD_ID_WIDTH 4
`define WD_LOOK_BITS 2

// open transactions per ID, and open W bursts
`define WD_CNT_WIDTH 3

// W and B payload
`define WD_DATA_WIDTH 32
`define WD_RESP_WIDTH 2

`endif

//--- common/wr_demux_pkg.sv
// --------------------------------------------------
// shared types and FSM state enums of the write demux
// --------------------------------------------------
`include "wr_demux_consts.svh"

package wr_demux_pkg;

  // port index on the master side
  typedef logic [`WD_SEL_WIDTH-1:0] port_sel_t;

  // full AXI ID and the tracked low bits
  typedef logic [`WD_ID_WIDTH-1:0] axi_id_t;
  typedef logic [`WD_LOOK_BITS-1:0] look_id_t;

  // in-flight counter value
  typedef logic [`WD_CNT_WIDTH-1:0] cnt_t;

  // W data and B response
  typedef logic [`WD_DATA_WIDTH-1:0] data_t;
  typedef logic [`WD_RESP_WIDTH-1:0] resp_t;

  // AW steering
  // idle waits for an admissible AW, locked holds valid until ready
  typedef enum logic {
    AW_IDLE,
    AW_LOCKED
  } aw_state_e;

  // B arbiter
  // held keeps the grant until the slave side takes the response
  typedef enum logic {
    ARB_FREE,
    ARB_HELD
  } arb_state_e;

endpackage

//--- hdl/wr_id_tracker.sv
// --------------------------------------------------
// per-ID in-flight write counters and target port
// --------------------------------------------------
`timescale 1ns/1ps
`include "wr_demux_consts.svh"

module wr_id_tracker (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // lookup of the AW waiting on the slave port
  input  wr_demux_pkg::look_id_t  lookup_id_i,
  output wr_demux_pkg::port_sel_t lookup_sel_o,
  output logic                    lookup_busy_o,
  output logic                    full_o,
  // push on an AW decision
  input  logic                    push_i,
  input  wr_demux_pkg::look_id_t  push_id_i,
  input  wr_demux_pkg::port_sel_t push_sel_i,
  // pop on a slave-side B handshake
  input  logic                    pop_i,
  input  wr_demux_pkg::look_id_t  pop_id_i
);

  localparam int NUM_IDS = 2 ** `WD_LOOK_BITS;

  // one counter and one stored port per tracked ID
  wr_demux_pkg::cnt_t      cnt_q [NUM_IDS];
  wr_demux_pkg::port_sel_t sel_q [NUM_IDS];
  logic [NUM_IDS-1:0]      cnt_full;

  // --------------------------------------------------
  // lookup
  // --------------------------------------------------
  // port is only meaningful while the ID is busy
  assign lookup_sel_o  = sel_q[lookup_id_i];
  assign lookup_busy_o = (cnt_q[lookup_id_i] != '0);
  // stop all admissions once any counter saturates
  assign full_o        = |cnt_full;

  // --------------------------------------------------
  // counters
  // --------------------------------------------------
  for (genvar i = 0; i < NUM_IDS; i++) begin : gen_ids
    logic push_en;
    logic pop_en;

    assign push_en     = push_i && (push_id_i == wr_demux_pkg::look_id_t'(i));
    assign pop_en      = pop_i && (pop_id_i == wr_demux_pkg::look_id_t'(i));
    assign cnt_full[i] = &cnt_q[i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        cnt_q[i] <= '0;
      end else begin
        // push and pop together cancel out
        unique case ({push_en, pop_en})
          2'b10:   cnt_q[i] <= cnt_q[i] + wr_demux_pkg::cnt_t'(1);
          2'b01:   cnt_q[i] <= cnt_q[i] - wr_demux_pkg::cnt_t'(1);
          default: cnt_q[i] <= cnt_q[i];
        endcase
      end
    end

    // target port of the newest write with this ID
    always_ff @(posedge clk_i) begin
      if (push_en) begin
        sel_q[i] <= push_sel_i;
      end
    end
  end

  // a B from the ports must belong to a write that was pushed earlier
  a_pop_nonzero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> (cnt_q[pop_id_i] != '0));

  // AW admission must hold off pushes while a counter is saturated
  a_push_not_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push_i |-> !full_o);

endmodule

//--- write_demux/aw_steer.sv
// --------------------------------------------------
// AW admission, valid locking and master port steering
// --------------------------------------------------
`timescale 1ns/1ps
`include "wr_demux_consts.svh"

module aw_steer (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // slave-side AW handshake and select
  input  logic                    s_aw_valid_i,
  input  wr_demux_pkg::port_sel_t s_aw_sel_i,
  output logic                    s_aw_ready_o,
  // master-side AW handshake
  output logic [`WD_NUM_PORTS-1:0] m_aw_valid_o,
  input  logic [`WD_NUM_PORTS-1:0] m_aw_ready_i,
  // ID tracker lookup
  input  wr_demux_pkg::port_sel_t lookup_sel_i,
  input  logic                    lookup_busy_i,
  input  logic                    id_full_i,
  // W route status
  input  logic                    w_ok_i,
  input  logic                    w_full_i,
  // one pulse per AW decision
  output logic                    aw_push_o
);

  wr_demux_pkg::aw_state_e state_d;
  wr_demux_pkg::aw_state_e state_q;
  logic                    id_ok;
  logic                    admit;
  logic                    aw_valid;
  logic                    sel_ready;

  // --------------------------------------------------
  // admission
  // --------------------------------------------------
  // an ID with open writes may only go to the port it already uses
  assign id_ok     = !lookup_busy_i || (lookup_sel_i == s_aw_sel_i);
  // W bursts must not need two ports at once, so the W side has a say too
  assign admit     = s_aw_valid_i && !id_full_i && !w_full_i && w_ok_i && id_ok;
  assign sel_ready = m_aw_ready_i[s_aw_sel_i];

  always_comb begin
    state_d   = state_q;
    aw_valid  = 1'b0;
    aw_push_o = 1'b0;
    unique case (state_q)
      wr_demux_pkg::AW_IDLE: begin
        if (admit) begin
          aw_valid  = 1'b1;
          // decision goes to tracker and W route even if ready is missing
          aw_push_o = 1'b1;
          if (!sel_ready) begin
            state_d = wr_demux_pkg::AW_LOCKED;
          end
        end
      end
      wr_demux_pkg::AW_LOCKED: begin
        // already pushed, only wait for the port
        aw_valid = 1'b1;
        if (sel_ready) begin
          state_d = wr_demux_pkg::AW_IDLE;
        end
      end
      default: state_d = wr_demux_pkg::AW_IDLE;
    endcase
  end

  // --------------------------------------------------
  // steering
  // --------------------------------------------------
  assign s_aw_ready_o = aw_valid && sel_ready;

  always_comb begin
    m_aw_valid_o             = '0;
    m_aw_valid_o[s_aw_sel_i] = aw_valid;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= wr_demux_pkg::AW_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // the locked state relies on the slave side keeping its request up
  a_aw_valid_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (s_aw_valid_i && !s_aw_ready_o) |=> s_aw_valid_i);

  // the slave side must not move the select of a locked request
  a_sel_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (state_q == wr_demux_pkg::AW_LOCKED) |-> $stable(s_aw_sel_i));

endmodule

//--- write_demux/w_route.sv
// --------------------------------------------------
// open-burst counter and W beat steering
// --------------------------------------------------
`timescale 1ns/1ps
`include "wr_demux_consts.svh"

module w_route (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  // AW decision from the steering block
  input  logic                     aw_push_i,
  input  wr_demux_pkg::port_sel_t  aw_sel_i,
  // slave-side W handshake
  input  logic                     s_w_valid_i,
  input  logic                     s_w_last_i,
  output logic                     s_w_ready_o,
  // master-side W handshake
  output logic [`WD_NUM_PORTS-1:0] m_w_valid_o,
  input  logic [`WD_NUM_PORTS-1:0] m_w_ready_i,
  // status back to AW admission
  output logic                     w_ok_o,
  output logic                     w_full_o
);

  wr_demux_pkg::cnt_t      w_open_q;
  wr_demux_pkg::port_sel_t w_sel_q;
  wr_demux_pkg::port_sel_t w_sel;
  logic                    w_sel_valid;
  logic                    w_down;

  // with no burst open the fresh AW decision steers directly
  assign w_sel       = (w_open_q != '0) ? w_sel_q : aw_sel_i;
  assign w_sel_valid = aw_push_i || (w_open_q != '0);

  // all open bursts share one port, a new one must match it
  assign w_ok_o   = (w_open_q == '0) || (w_sel_q == aw_sel_i);
  assign w_full_o = &w_open_q;

  // W beats pass through combinationally
  always_comb begin
    m_w_valid_o        = '0;
    m_w_valid_o[w_sel] = s_w_valid_i && w_sel_valid;
  end
  assign s_w_ready_o = w_sel_valid && m_w_ready_i[w_sel];
  assign w_down      = s_w_valid_i && s_w_ready_o && s_w_last_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      w_open_q <= '0;
      w_sel_q  <= '0;
    end else begin
      // single-beat burst decided and closed in one cycle leaves the count alone
      unique case ({aw_push_i, w_down})
        2'b10:   w_open_q <= w_open_q + wr_demux_pkg::cnt_t'(1);
        2'b01:   w_open_q <= w_open_q - wr_demux_pkg::cnt_t'(1);
        default: w_open_q <= w_open_q;
      endcase
      if (aw_push_i) begin
        w_sel_q <= aw_sel_i;
      end
    end
  end

  // AW admission must hold off new bursts while the counter is saturated
  a_w_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    aw_push_i |-> !w_full_o);

endmodule

//--- write_demux/b_arbiter.sv
// --------------------------------------------------
// round-robin B arbiter with lock-in until handshake
// --------------------------------------------------
`timescale 1ns/1ps
`include "wr_demux_consts.svh"

module b_arbiter (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  // master-side B channels
  input  logic [`WD_NUM_PORTS-1:0]                     m_b_valid_i,
  output logic [`WD_NUM_PORTS-1:0]                     m_b_ready_o,
  input  wr_demux_pkg::axi_id_t [`WD_NUM_PORTS-1:0]    m_b_id_i,
  input  wr_demux_pkg::resp_t [`WD_NUM_PORTS-1:0]      m_b_resp_i,
  // slave-side B channel
  output logic                                         s_b_valid_o,
  input  logic                                         s_b_ready_i,
  output wr_demux_pkg::axi_id_t                        s_b_id_o,
  output wr_demux_pkg::resp_t                          s_b_resp_o,
  // tracker pop
  output logic                                         pop_o,
  output wr_demux_pkg::look_id_t                       pop_id_o
);

  wr_demux_pkg::arb_state_e state_q;
  wr_demux_pkg::port_sel_t  rr_q;
  wr_demux_pkg::port_sel_t  gnt_q;
  wr_demux_pkg::port_sel_t  pick;
  wr_demux_pkg::port_sel_t  idx;
  logic                     found;
  logic                     held;
  logic                     b_hs;

  // --------------------------------------------------
  // round-robin search
  // --------------------------------------------------
  // first valid port at or after the pointer
  always_comb begin : rr_search
    wr_demux_pkg::port_sel_t cand;
    pick  = rr_q;
    found = 1'b0;
    cand  = rr_q;
    for (int k = 0; k < `WD_NUM_PORTS; k++) begin
      cand = rr_q + wr_demux_pkg::port_sel_t'(k);
      if (!found && m_b_valid_i[cand]) begin
        pick  = cand;
        found = 1'b1;
      end
    end
  end

  // a stalled grant is kept, zero latency otherwise
  assign held        = (state_q == wr_demux_pkg::ARB_HELD);
  assign idx         = held ? gnt_q : pick;
  assign s_b_valid_o = held ? m_b_valid_i[gnt_q] : found;
  assign s_b_id_o    = m_b_id_i[idx];
  assign s_b_resp_o  = m_b_resp_i[idx];
  assign b_hs        = s_b_valid_o && s_b_ready_i;

  always_comb begin
    m_b_ready_o      = '0;
    m_b_ready_o[idx] = b_hs;
  end

  // each completed B closes one write of its ID
  assign pop_o    = b_hs;
  assign pop_id_o = s_b_id_o[`WD_LOOK_BITS-1:0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= wr_demux_pkg::ARB_FREE;
      rr_q    <= '0;
      gnt_q   <= '0;
    end else if (b_hs) begin
      state_q <= wr_demux_pkg::ARB_FREE;
      // served port goes to the back of the line
      rr_q    <= idx + wr_demux_pkg::port_sel_t'(1);
    end else if (!held && found) begin
      state_q <= wr_demux_pkg::ARB_HELD;
      gnt_q   <= pick;
    end
  end

  // slave side sees the same response until it takes it
  a_b_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (s_b_valid_o && !s_b_ready_i) |=> (s_b_valid_o && $stable(s_b_id_o)));

endmodule

//--- hdl/wr_demux_top.sv
// --------------------------------------------------
// write demux top: AW steering, W route, B arbiter
// and ID tracker between one slave and N master ports
// --------------------------------------------------
`timescale 1ns/1ps
`include "wr_demux_consts.svh"

module wr_demux_top (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  // slave-side AW
  input  logic                                      s_aw_valid_i,
  input  wr_demux_pkg::axi_id_t                     s_aw_id_i,
  input  wr_demux_pkg::port_sel_t                   s_aw_sel_i,
  output logic                                      s_aw_ready_o,
  // slave-side W
  input  logic                                      s_w_valid_i,
  input  wr_demux_pkg::data_t                       s_w_data_i,
  input  logic                                      s_w_last_i,
  output logic                                      s_w_ready_o,
  // slave-side B
  output logic                                      s_b_valid_o,
  output wr_demux_pkg::axi_id_t                     s_b_id_o,
  output wr_demux_pkg::resp_t                       s_b_resp_o,
  input  logic                                      s_b_ready_i,
  // master-side AW
  output logic [`WD_NUM_PORTS-1:0]                  m_aw_valid_o,
  input  logic [`WD_NUM_PORTS-1:0]                  m_aw_ready_i,
  output wr_demux_pkg::axi_id_t                     m_aw_id_o,
  // master-side W
  output logic [`WD_NUM_PORTS-1:0]                  m_w_valid_o,
  input  logic [`WD_NUM_PORTS-1:0]                  m_w_ready_i,
  output wr_demux_pkg::data_t                       m_w_data_o,
  output logic                                      m_w_last_o,
  // master-side B
  input  logic [`WD_NUM_PORTS-1:0]                  m_b_valid_i,
  output logic [`WD_NUM_PORTS-1:0]                  m_b_ready_o,
  input  wr_demux_pkg::axi_id_t [`WD_NUM_PORTS-1:0] m_b_id_i,
  input  wr_demux_pkg::resp_t [`WD_NUM_PORTS-1:0]   m_b_resp_i
);

  wr_demux_pkg::port_sel_t lookup_sel;
  wr_demux_pkg::look_id_t  pop_id;
  logic                    lookup_busy;
  logic                    id_full;
  logic                    aw_push;
  logic                    w_ok;
  logic                    w_full;
  logic                    pop;

  // payload is shared, only the valids are steered
  assign m_aw_id_o  = s_aw_id_i;
  assign m_w_data_o = s_w_data_i;
  assign m_w_last_o = s_w_last_i;

  wr_id_tracker i_wr_id_tracker (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .lookup_id_i   (s_aw_id_i[`WD_LOOK_BITS-1:0]),
    .lookup_sel_o  (lookup_sel),
    .lookup_busy_o (lookup_busy),
    .full_o        (id_full),
    .push_i        (aw_push),
    .push_id_i     (s_aw_id_i[`WD_LOOK_BITS-1:0]),
    .push_sel_i    (s_aw_sel_i),
    .pop_i         (pop),
    .pop_id_i      (pop_id)
  );

  aw_steer i_aw_steer (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .s_aw_valid_i  (s_aw_valid_i),
    .s_aw_sel_i    (s_aw_sel_i),
    .s_aw_ready_o  (s_aw_ready_o),
    .m_aw_valid_o  (m_aw_valid_o),
    .m_aw_ready_i  (m_aw_ready_i),
    .lookup_sel_i  (lookup_sel),
    .lookup_busy_i (lookup_busy),
    .id_full_i     (id_full),
    .w_ok_i        (w_ok),
    .w_full_i      (w_full),
    .aw_push_o     (aw_push)
  );

  w_route i_w_route (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .aw_push_i   (aw_push),
    .aw_sel_i    (s_aw_sel_i),
    .s_w_valid_i (s_w_valid_i),
    .s_w_last_i  (s_w_last_i),
    .s_w_ready_o (s_w_ready_o),
    .m_w_valid_o (m_w_valid_o),
    .m_w_ready_i (m_w_ready_i),
    .w_ok_o      (w_ok),
    .w_full_o    (w_full)
  );

  b_arbiter i_b_arbiter (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .m_b_valid_i (m_b_valid_i),
    .m_b_ready_o (m_b_ready_o),
    .m_b_id_i    (m_b_id_i),
    .m_b_resp_i  (m_b_resp_i),
    .s_b_valid_o (s_b_valid_o),
    .s_b_ready_i (s_b_ready_i),
    .s_b_id_o    (s_b_id_o),
    .s_b_resp_o  (s_b_resp_o),
    .pop_o       (pop),
    .pop_id_o    (pop_id)
  );

endmodule

//--- bench/tb_wr_demux.sv
// --------------------------------------------------
// testbench for the write demux: random AXI master and
// slave models, B reference function, checker, watchdog
// --------------------------------------------------
`timescale 1ns/1ps
`include "wr_demux_consts.svh"

module tb_wr_demux;

  localparam int NP         = `WD_NUM_PORTS;
  localparam int N_TXN      = 200;
  localparam int CLK_PERIOD = 40;

  logic                                      clk_i;
  logic                                      arst_n_i;
  logic                                      s_aw_valid_i;
  wr_demux_pkg::axi_id_t                     s_aw_id_i;
  wr_demux_pkg::port_sel_t                   s_aw_sel_i;
  logic                                      s_aw_ready_o;
  logic                                      s_w_valid_i;
  wr_demux_pkg::data_t                       s_w_data_i;
  logic                                      s_w_last_i;
  logic                                      s_w_ready_o;
  logic                                      s_b_valid_o;
  wr_demux_pkg::axi_id_t                     s_b_id_o;
  wr_demux_pkg::resp_t                       s_b_resp_o;
  logic                                      s_b_ready_i;
  logic [NP-1:0]                             m_aw_valid_o;
  logic [NP-1:0]                             m_aw_ready_i;
  wr_demux_pkg::axi_id_t                     m_aw_id_o;
  logic [NP-1:0]                             m_w_valid_o;
  logic [NP-1:0]                             m_w_ready_i;
  wr_demux_pkg::data_t                       m_w_data_o;
  logic                                      m_w_last_o;
  logic [NP-1:0]                             m_b_valid_i;
  logic [NP-1:0]                             m_b_ready_o;
  wr_demux_pkg::axi_id_t [NP-1:0]            m_b_id_i;
  wr_demux_pkg::resp_t [NP-1:0]              m_b_resp_i;

  // transaction list
  logic [3:0]  t_id [N_TXN];
  logic [1:0]  t_sel [N_TXN];
  int          t_len [N_TXN];
  logic [31:0] t_data [N_TXN];
  logic        t_aw_done [N_TXN];
  logic        t_b_done [N_TXN];

  // master and slave model state
  logic [31:0] seed;
  logic        started;
  int          aw_idx;
  int          w_idx;
  int          w_beat;
  int          aw_mon;
  int          b_count;
  int          wp_txn [NP];
  int          wp_beat [NP];
  int          done_cnt [NP];
  logic [3:0]  rx_id [NP][N_TXN];
  int          rx_head [NP];
  int          rx_tail [NP];

  wr_demux_top i_wr_demux_top (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // next transaction at or after from that targets port p
  function automatic int next_at(int p, int from);
    for (int i = from; i < N_TXN; i++) begin
      if (int'(t_sel[i]) == p) return i;
    end
    return N_TXN;
  endfunction

  // oldest open write with the same tracked ID
  // writes of one tracked ID share a port that answers in order
  // response rule is port XOR ID
  function automatic int expect_b(logic [3:0] id, output logic [1:0] resp);
    resp = 2'b00;
    for (int i = 0; i < N_TXN; i++) begin
      if (t_aw_done[i] && !t_b_done[i] && t_id[i][1:0] == id[1:0]) begin
        resp = t_sel[i] ^ t_id[i][1:0];
        return i;
      end
    end
    return -1;
  endfunction

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic fail_msg(string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  // --------------------------------------------------
  // master and slave models, master-side monitors
  // --------------------------------------------------
  always @(posedge clk_i) begin : drive_and_monitor
    logic [31:0] r;
    int          k;
    logic [1:0]  rsp;
    r = lcg_next();
    if (arst_n_i && started) begin
      // slave-side AW source, in list order
      if (!s_aw_valid_i || s_aw_ready_o) begin
        if (s_aw_valid_i) aw_idx++;
        if (aw_idx < N_TXN && r[31]) begin
          s_aw_valid_i <= 1'b1;
          s_aw_id_i    <= t_id[aw_idx];
          s_aw_sel_i   <= t_sel[aw_idx];
        end else begin
          s_aw_valid_i <= 1'b0;
        end
      end
      // slave-side W source, bursts in AW order
      if (!s_w_valid_i || s_w_ready_o) begin
        if (s_w_valid_i) begin
          if (w_beat == t_len[w_idx] - 1) begin
            w_idx++;
            w_beat = 0;
          end else begin
            w_beat++;
          end
        end
        if (w_idx < N_TXN && r[30]) begin
          s_w_valid_i <= 1'b1;
          s_w_data_i  <= t_data[w_idx] ^ 32'(w_beat);
          s_w_last_i  <= (w_beat == t_len[w_idx] - 1);
        end else begin
          s_w_valid_i <= 1'b0;
        end
      end
      for (int p = 0; p < NP; p++) begin
        // AW arriving at port p
        if (m_aw_valid_o[p] && m_aw_ready_i[p]) begin
          if (aw_mon >= N_TXN) fail_msg("an AW came out with no transaction left");
          check("m_aw_valid_o count", 32'($countones(m_aw_valid_o)), 32'd1);
          check("m_aw_valid_o port", 32'(p), 32'(t_sel[aw_mon]));
          check("m_aw_id_o", 32'(m_aw_id_o), 32'(t_id[aw_mon]));
          // same tracked ID must not be open at a different port
          for (int i = 0; i < N_TXN; i++) begin
            if (t_aw_done[i] && !t_b_done[i] && t_id[i][1:0] == m_aw_id_o[1:0]
                && int'(t_sel[i]) != p) begin
              fail_msg("an AW was issued while its ID had writes open at another port");
            end
          end
          t_aw_done[aw_mon] = 1'b1;
          rx_id[p][rx_tail[p]] = m_aw_id_o;
          rx_tail[p]++;
          aw_mon++;
        end
        // W beats arriving at port p
        if (m_w_valid_o[p] && m_w_ready_i[p]) begin
          k = wp_txn[p];
          if (k >= N_TXN) fail_msg("a W beat came out at a port with no burst left");
          check("m_w_data_o", m_w_data_o, t_data[k] ^ 32'(wp_beat[p]));
          check("m_w_last_o", 32'(m_w_last_o), 32'(wp_beat[p] == t_len[k] - 1));
          if (m_w_last_o) begin
            done_cnt[p]++;
            wp_txn[p]  = next_at(p, k + 1);
            wp_beat[p] = 0;
          end else begin
            wp_beat[p]++;
          end
        end
        // B answer once AW and whole burst are in
        if (m_b_valid_i[p] && m_b_ready_o[p]) begin
          rx_head[p]++;
          done_cnt[p]--;
          m_b_valid_i[p] <= 1'b0;
        end else if (!m_b_valid_i[p] && rx_head[p] < rx_tail[p] && done_cnt[p] > 0
                     && r[20-p]) begin
          rsp = 2'(p) ^ rx_id[p][rx_head[p]][1:0];
          m_b_valid_i[p] <= 1'b1;
          m_b_id_i[p]    <= rx_id[p][rx_head[p]];
          m_b_resp_i[p]  <= rsp;
        end
      end
      // random stalls on every ready
      m_aw_ready_i <= r[29:26];
      m_w_ready_i  <= r[25:22];
      s_b_ready_i  <= r[21];
    end
  end

  // --------------------------------------------------
  // slave-side B compare
  // --------------------------------------------------
  always @(posedge clk_i) begin : compare_b
    int         idx;
    logic [1:0] exp_resp;
    if (arst_n_i && s_b_valid_o && s_b_ready_i) begin
      idx = expect_b(s_b_id_o, exp_resp);
      if (idx < 0) begin
        fail_msg("a B response came back with no open write for its ID");
      end else begin
        check("s_b_id_o", 32'(s_b_id_o), 32'(t_id[idx]));
        check("s_b_resp_o", 32'(s_b_resp_o), 32'(exp_resp));
        t_b_done[idx] = 1'b1;
        b_count++;
      end
    end
  end

  // run time scales with the number of writes
  initial begin : watchdog
    #(N_TXN * 60 * CLK_PERIOD);
    $display("timeout: not all writes completed in time");
    $display("Simulation FAILED");
    $fatal(1);
  end

  initial begin : run
    logic [31:0] r;
    seed = 32'h4ef5d42d;
    clk_i = 1'b0;
    arst_n_i = 1'b0;
    started = 1'b0;
    s_aw_valid_i = 1'b0;
    s_aw_id_i = '0;
    s_aw_sel_i = '0;
    s_w_valid_i = 1'b0;
    s_w_data_i = '0;
    s_w_last_i = 1'b0;
    s_b_ready_i = 1'b0;
    m_aw_ready_i = '0;
    m_w_ready_i = '0;
    m_b_valid_i = '0;
    m_b_id_i = '0;
    m_b_resp_i = '0;
    aw_idx = 0;
    w_idx = 0;
    w_beat = 0;
    aw_mon = 0;
    b_count = 0;
    for (int i = 0; i < N_TXN; i++) begin
      r = lcg_next();
      t_len[i]     = 1 + int'(r[31:30]);
      t_id[i]      = r[27:24];
      t_sel[i]     = r[21:20];
      t_data[i]    = lcg_next();
      t_aw_done[i] = 1'b0;
      t_b_done[i]  = 1'b0;
    end
    for (int p = 0; p < NP; p++) begin
      wp_txn[p]   = next_at(p, 0);
      wp_beat[p]  = 0;
      done_cnt[p] = 0;
      rx_head[p]  = 0;
      rx_tail[p]  = 0;
    end
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    // readies are up while no valid is offered
    // every handshake output must stay low
    m_aw_ready_i <= '1;
    m_w_ready_i  <= '1;
    s_b_ready_i  <= 1'b1;
    repeat (3) begin
      @(posedge clk_i);
      check("s_aw_ready_o", 32'(s_aw_ready_o), 32'h0);
      check("s_w_ready_o", 32'(s_w_ready_o), 32'h0);
      check("s_b_valid_o", 32'(s_b_valid_o), 32'h0);
      check("m_aw_valid_o", 32'(m_aw_valid_o), 32'h0);
      check("m_w_valid_o", 32'(m_w_valid_o), 32'h0);
      check("m_b_ready_o", 32'(m_b_ready_o), 32'h0);
    end
    started <= 1'b1;
    while (b_count < N_TXN) @(posedge clk_i);
    @(posedge clk_i);
    if (aw_mon != N_TXN || wp_txn[0] != N_TXN || wp_txn[1] != N_TXN
        || wp_txn[2] != N_TXN || wp_txn[3] != N_TXN) begin
      fail_msg("writes are left unfinished after the last B response");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

//--- filelist.f
+incdir+common
common/wr_demux_pkg.sv
hdl/wr_id_tracker.sv
write_demux/aw_steer.sv
write_demux/w_route.sv
write_demux/b_arbiter.sv
hdl/wr_demux_top.sv
bench/tb_wr_demux.sv

//--- Makefile
TOP := tb_wr_demux

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 -f filelist.f --top-module $(TOP)

run: build
	out="$$(./obj_dir/V$(TOP))"; status=$$?; echo "$$out"; \
	test $$status -eq 0 && echo "$$out" | grep -q "Simulation PASSED"

lint:
	verilator --lint-only -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
